/* rtl/gpio_regs_pkg.sv */
package gpio_regs_pkg;

  // --------------------
  // Bus and port types
  // --------------------

  // Byte address on the AXI bus
  typedef logic [8:0] addr_t;

  // Word offset, byte address without its two low bits
  typedef logic [6:0] word_addr_t;

  typedef logic [31:0] data_t;
  typedef logic [1:0]  resp_t;
  typedef logic [31:0] gpio_t;

  // One bit per interrupt channel
  typedef logic [1:0] irq_vec_t;

  localparam int NUM_IRQ_CH = 2;

  // --------------------
  // Response codes
  // --------------------

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------
  // Register word offsets
  // --------------------

  localparam word_addr_t REG_GPIO_DATA  = 7'd0;
  localparam word_addr_t REG_GPIO_TRI   = 7'd1;
  localparam word_addr_t REG_GPIO2_DATA = 7'd2;
  localparam word_addr_t REG_GPIO2_TRI  = 7'd3;

  // Interrupt block, word 75 left unmapped
  localparam word_addr_t REG_IRQ_STAT  = 7'd71;
  localparam word_addr_t REG_IRQ_TRAP  = 7'd72;
  localparam word_addr_t REG_IRQ_MASK  = 7'd73;
  localparam word_addr_t REG_IRQ_FORCE = 7'd74;
  localparam word_addr_t REG_IRQ_TRIG  = 7'd76;

  // Returned on reads of an unmapped offset
  localparam data_t UNMAPPED_DATA = 32'hDEADBEEF;

endpackage

/* rtl/axil_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_ctrl
  import gpio_regs_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  addr_t      awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  data_t      wdata,
  input  logic       wvalid,
  output logic       wready,
  output resp_t      bresp,
  output logic       bvalid,
  input  logic       bready,
  input  addr_t      araddr,
  input  logic       arvalid,
  output logic       arready,
  output data_t      rdata,
  output resp_t      rresp,
  output logic       rvalid,
  input  logic       rready,
  output logic       wr_req,
  output word_addr_t wr_addr,
  output data_t      wr_data,
  input  logic       wr_hit,
  output logic       rd_req,
  output word_addr_t rd_addr,
  input  logic       rd_hit,
  input  data_t      rd_data
);

  // --------------------
  // Write FSM
  // --------------------

  // WR_ADDR holds an address and waits for data, WR_DATA the reverse
  typedef enum logic [2:0] {
    WR_RESET,
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_REQ,
    WR_DEC,
    WR_RESP
  } wr_state_t;

  wr_state_t wr_state;
  wr_state_t wr_state_next;
  logic      wr_accept;
  logic      aw_take;
  logic      w_take;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_state <= WR_RESET;
    end else begin
      wr_state <= wr_state_next;
    end
  end

  always_comb begin
    case (wr_state)
      WR_RESET: wr_state_next = WR_IDLE;
      WR_IDLE: begin
        if (awvalid && wvalid) begin
          wr_state_next = WR_REQ;
        end else if (awvalid) begin
          wr_state_next = WR_ADDR;
        end else if (wvalid) begin
          wr_state_next = WR_DATA;
        end else begin
          wr_state_next = WR_IDLE;
        end
      end
      WR_ADDR: wr_state_next = wvalid ? WR_REQ : WR_ADDR;
      WR_DATA: wr_state_next = awvalid ? WR_REQ : WR_DATA;
      WR_REQ:  wr_state_next = WR_DEC;
      WR_DEC:  wr_state_next = WR_RESP;
      WR_RESP: wr_state_next = bready ? WR_IDLE : WR_RESP;
      default: wr_state_next = WR_RESET;
    endcase
  end

  assign aw_take   = awvalid && (wr_state == WR_IDLE || wr_state == WR_DATA);
  assign w_take    = wvalid && (wr_state == WR_IDLE || wr_state == WR_ADDR);
  assign wr_accept = (wr_state != WR_REQ) && (wr_state_next == WR_REQ);

  // Address and data held until the next accepted write
  always_ff @(posedge aclk) begin
    if (aw_take) begin
      wr_addr <= awaddr[8:2];
    end
    if (w_take) begin
      wr_data <= wdata;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      wr_req  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= RESP_OKAY;
    end else begin
      awready <= (wr_state_next == WR_IDLE) || (wr_state_next == WR_DATA);
      wready  <= (wr_state_next == WR_IDLE) || (wr_state_next == WR_ADDR);
      wr_req  <= wr_accept;
      bvalid  <= (wr_state_next == WR_RESP);
      if (wr_state == WR_DEC) begin
        bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

  // --------------------
  // Read FSM
  // --------------------

  typedef enum logic [2:0] {
    RD_RESET,
    RD_IDLE,
    RD_REQ,
    RD_DEC,
    RD_RESP
  } rd_state_t;

  rd_state_t rd_state;
  rd_state_t rd_state_next;
  logic      ar_take;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_state <= RD_RESET;
    end else begin
      rd_state <= rd_state_next;
    end
  end

  always_comb begin
    case (rd_state)
      RD_RESET: rd_state_next = RD_IDLE;
      RD_IDLE:  rd_state_next = arvalid ? RD_REQ : RD_IDLE;
      RD_REQ:   rd_state_next = RD_DEC;
      RD_DEC:   rd_state_next = RD_RESP;
      RD_RESP:  rd_state_next = rready ? RD_IDLE : RD_RESP;
      default:  rd_state_next = RD_RESET;
    endcase
  end

  assign ar_take = arvalid && (rd_state == RD_IDLE);

  always_ff @(posedge aclk) begin
    if (ar_take) begin
      rd_addr <= araddr[8:2];
    end
  end

  // Data and response latched once, held under back-pressure
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arready <= 1'b0;
      rd_req  <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= RESP_OKAY;
      rdata   <= '0;
    end else begin
      arready <= (rd_state_next == RD_IDLE);
      rd_req  <= ar_take;
      rvalid  <= (rd_state_next == RD_RESP);
      if (rd_state == RD_DEC) begin
        rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        rdata <= rd_data;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/gpio_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_addr_decode
  import gpio_regs_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       wr_req,
  input  word_addr_t wr_addr,
  input  logic       rd_req,
  input  word_addr_t rd_addr,
  input  gpio_t      gpio_data_in_q,
  input  gpio_t      gpio_tri,
  input  gpio_t      gpio2_data_in_q,
  input  gpio_t      gpio2_tri,
  input  irq_vec_t   irq_int,
  input  irq_vec_t   irq_trap,
  input  irq_vec_t   irq_mask,
  input  irq_vec_t   irq_force,
  input  irq_vec_t   irq_trig,
  output logic       wr_hit,
  output logic       rd_hit,
  output logic       gpio_data_we,
  output logic       gpio_tri_we,
  output logic       gpio2_data_we,
  output logic       gpio2_tri_we,
  output logic       trap_we,
  output logic       mask_we,
  output logic       force_we,
  output logic       trig_we,
  output data_t      rd_data
);

  function automatic logic is_mapped(input word_addr_t addr);
    is_mapped = (addr <= REG_GPIO2_TRI) ||
                (addr >= REG_IRQ_STAT && addr <= REG_IRQ_FORCE) ||
                (addr == REG_IRQ_TRIG);
  endfunction

  assign wr_hit = is_mapped(wr_addr);
  assign rd_hit = is_mapped(rd_addr);

  // Strobes, one per writable register
  assign gpio_data_we  = wr_req && (wr_addr == REG_GPIO_DATA);
  assign gpio_tri_we   = wr_req && (wr_addr == REG_GPIO_TRI);
  assign gpio2_data_we = wr_req && (wr_addr == REG_GPIO2_DATA);
  assign gpio2_tri_we  = wr_req && (wr_addr == REG_GPIO2_TRI);
  assign trap_we       = wr_req && (wr_addr == REG_IRQ_TRAP);
  assign mask_we       = wr_req && (wr_addr == REG_IRQ_MASK);
  assign force_we      = wr_req && (wr_addr == REG_IRQ_FORCE);
  assign trig_we       = wr_req && (wr_addr == REG_IRQ_TRIG);

  // Data words return the sampled input, not the output register
  always_ff @(posedge aclk) begin
    if (aresetn && rd_req) begin
      case (rd_addr)
        REG_GPIO_DATA:  rd_data <= gpio_data_in_q;
        REG_GPIO_TRI:   rd_data <= gpio_tri;
        REG_GPIO2_DATA: rd_data <= gpio2_data_in_q;
        REG_GPIO2_TRI:  rd_data <= gpio2_tri;
        REG_IRQ_STAT:   rd_data <= data_t'(irq_int);
        REG_IRQ_TRAP:   rd_data <= data_t'(irq_trap);
        REG_IRQ_MASK:   rd_data <= data_t'(irq_mask);
        REG_IRQ_FORCE:  rd_data <= data_t'(irq_force);
        REG_IRQ_TRIG:   rd_data <= data_t'(irq_trig);
        default:        rd_data <= UNMAPPED_DATA;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/gpio_port_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_port_regs
  import gpio_regs_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  input  data_t wr_data,
  input  logic  gpio_data_we,
  input  logic  gpio_tri_we,
  input  logic  gpio2_data_we,
  input  logic  gpio2_tri_we,
  input  gpio_t gpio_data_in,
  input  gpio_t gpio2_data_in,
  output gpio_t gpio_data_out,
  output gpio_t gpio_tri,
  output gpio_t gpio2_data_out,
  output gpio_t gpio2_tri,
  output gpio_t gpio_data_in_q,
  output gpio_t gpio2_data_in_q
);

  // --------------------
  // Output and tri-state
  // --------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      gpio_data_out  <= '0;
      gpio_tri       <= '0;
      gpio2_data_out <= '0;
      gpio2_tri      <= '0;
    end else begin
      if (gpio_data_we) gpio_data_out <= wr_data;
      if (gpio_tri_we) gpio_tri <= wr_data;
      if (gpio2_data_we) gpio2_data_out <= wr_data;
      if (gpio2_tri_we) gpio2_tri <= wr_data;
    end
  end

  // Input sampling, every cycle
  always_ff @(posedge aclk) begin
    gpio_data_in_q  <= gpio_data_in;
    gpio2_data_in_q <= gpio2_data_in;
  end

endmodule

`default_nettype wire

/* rtl/gpio_irq_status.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_irq_status
  import gpio_regs_pkg::*;
(
  input  logic     aclk,
  input  logic     aresetn,
  input  data_t    wr_data,
  input  logic     trap_we,
  input  logic     mask_we,
  input  logic     force_we,
  input  logic     trig_we,
  input  irq_vec_t stat_in,
  output irq_vec_t irq_int,
  output irq_vec_t irq_trap,
  output irq_vec_t irq_mask,
  output irq_vec_t irq_force,
  output irq_vec_t irq_trig,
  output logic     irq
);

  irq_vec_t stat_s1;
  irq_vec_t stat_s2;
  irq_vec_t wr_bits;
  irq_vec_t trap_set;
  irq_vec_t trap_clr;

  assign wr_bits = wr_data[NUM_IRQ_CH-1:0];

  // Two sample stages; s2 only serves the edge detect
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      stat_s1 <= '0;
      stat_s2 <= '0;
    end else begin
      stat_s1 <= stat_in;
      stat_s2 <= stat_s1;
    end
  end

  // Level when trig is 0, rising edge when trig is 1
  assign trap_set = irq_force | (stat_s1 & (~stat_s2 | ~irq_trig));
  assign trap_clr = trap_we ? wr_bits : '0;

  // --------------------
  // Channel registers
  // --------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      irq_trap  <= '0;
      irq_mask  <= '0;
      irq_force <= '0;
      irq_trig  <= '0;
    end else begin
      // A clear wins over a set in the same cycle
      irq_trap  <= (irq_trap | trap_set) & ~trap_clr;
      irq_force <= force_we ? wr_bits : '0;
      if (mask_we) irq_mask <= wr_bits;
      if (trig_we) irq_trig <= wr_bits;
    end
  end

  // Masked status, then the combined interrupt
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      irq_int <= '0;
      irq     <= 1'b0;
    end else begin
      irq_int <= irq_trap & irq_mask;
      irq     <= |irq_int;
    end
  end

endmodule

`default_nettype wire

/* rtl/gpio_interrupt_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_interrupt_regs
  import gpio_regs_pkg::*;
(
  input  logic     aclk,
  input  logic     aresetn,
  // AXI4-Lite slave
  input  addr_t    s_axi_awaddr,
  input  logic     s_axi_awvalid,
  output logic     s_axi_awready,
  input  data_t    s_axi_wdata,
  input  logic     s_axi_wvalid,
  output logic     s_axi_wready,
  output resp_t    s_axi_bresp,
  output logic     s_axi_bvalid,
  input  logic     s_axi_bready,
  input  addr_t    s_axi_araddr,
  input  logic     s_axi_arvalid,
  output logic     s_axi_arready,
  output data_t    s_axi_rdata,
  output resp_t    s_axi_rresp,
  output logic     s_axi_rvalid,
  input  logic     s_axi_rready,
  // GPIO ports and interrupt
  input  gpio_t    gpio_data_in,
  output gpio_t    gpio_data_out,
  output gpio_t    gpio_tri,
  input  gpio_t    gpio2_data_in,
  output gpio_t    gpio2_data_out,
  output gpio_t    gpio2_tri,
  input  irq_vec_t stat_in,
  output logic     irq
);

  logic       wr_req;
  logic       rd_req;
  logic       wr_hit;
  logic       rd_hit;
  word_addr_t wr_addr;
  word_addr_t rd_addr;
  data_t      wr_data;
  data_t      rd_data;

  logic gpio_data_we;
  logic gpio_tri_we;
  logic gpio2_data_we;
  logic gpio2_tri_we;
  logic trap_we;
  logic mask_we;
  logic force_we;
  logic trig_we;

  gpio_t    gpio_data_in_q;
  gpio_t    gpio2_data_in_q;
  irq_vec_t irq_int;
  irq_vec_t irq_trap;
  irq_vec_t irq_mask;
  irq_vec_t irq_force;
  irq_vec_t irq_trig;

  axil_ctrl u_ctrl (
    .aclk    (aclk),
    .aresetn (aresetn),
    .awaddr  (s_axi_awaddr),
    .awvalid (s_axi_awvalid),
    .awready (s_axi_awready),
    .wdata   (s_axi_wdata),
    .wvalid  (s_axi_wvalid),
    .wready  (s_axi_wready),
    .bresp   (s_axi_bresp),
    .bvalid  (s_axi_bvalid),
    .bready  (s_axi_bready),
    .araddr  (s_axi_araddr),
    .arvalid (s_axi_arvalid),
    .arready (s_axi_arready),
    .rdata   (s_axi_rdata),
    .rresp   (s_axi_rresp),
    .rvalid  (s_axi_rvalid),
    .rready  (s_axi_rready),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_hit  (wr_hit),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_hit  (rd_hit),
    .rd_data (rd_data)
  );

  // Register map and readback
  gpio_addr_decode u_decode (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .wr_req          (wr_req),
    .wr_addr         (wr_addr),
    .rd_req          (rd_req),
    .rd_addr         (rd_addr),
    .gpio_data_in_q  (gpio_data_in_q),
    .gpio_tri        (gpio_tri),
    .gpio2_data_in_q (gpio2_data_in_q),
    .gpio2_tri       (gpio2_tri),
    .irq_int         (irq_int),
    .irq_trap        (irq_trap),
    .irq_mask        (irq_mask),
    .irq_force       (irq_force),
    .irq_trig        (irq_trig),
    .wr_hit          (wr_hit),
    .rd_hit          (rd_hit),
    .gpio_data_we    (gpio_data_we),
    .gpio_tri_we     (gpio_tri_we),
    .gpio2_data_we   (gpio2_data_we),
    .gpio2_tri_we    (gpio2_tri_we),
    .trap_we         (trap_we),
    .mask_we         (mask_we),
    .force_we        (force_we),
    .trig_we         (trig_we),
    .rd_data         (rd_data)
  );

  gpio_port_regs u_ports (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .wr_data         (wr_data),
    .gpio_data_we    (gpio_data_we),
    .gpio_tri_we     (gpio_tri_we),
    .gpio2_data_we   (gpio2_data_we),
    .gpio2_tri_we    (gpio2_tri_we),
    .gpio_data_in    (gpio_data_in),
    .gpio2_data_in   (gpio2_data_in),
    .gpio_data_out   (gpio_data_out),
    .gpio_tri        (gpio_tri),
    .gpio2_data_out  (gpio2_data_out),
    .gpio2_tri       (gpio2_tri),
    .gpio_data_in_q  (gpio_data_in_q),
    .gpio2_data_in_q (gpio2_data_in_q)
  );

  gpio_irq_status u_irq (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .wr_data   (wr_data),
    .trap_we   (trap_we),
    .mask_we   (mask_we),
    .force_we  (force_we),
    .trig_we   (trig_we),
    .stat_in   (stat_in),
    .irq_int   (irq_int),
    .irq_trap  (irq_trap),
    .irq_mask  (irq_mask),
    .irq_force (irq_force),
    .irq_trig  (irq_trig),
    .irq       (irq)
  );

endmodule

`default_nettype wire

/* sim/tb_gpio_regs.sv */
`timescale 1ns/1ps

module tb_gpio_regs
  import gpio_regs_pkg::*;
();

  // Several times the length of the test sequence
  localparam int MAX_CYCLES = 6000;

  typedef struct packed {
    gpio_t    gpio_out;
    gpio_t    gpio_tri;
    gpio_t    gpio2_out;
    gpio_t    gpio2_tri;
    irq_vec_t trap;
    irq_vec_t mask;
    irq_vec_t trig;
  } reg_model_t;

  logic     aclk = 1'b0;
  logic     aresetn;
  addr_t    awaddr;
  logic     awvalid;
  logic     awready;
  data_t    wdata;
  logic     wvalid;
  logic     wready;
  resp_t    bresp;
  logic     bvalid;
  logic     bready;
  addr_t    araddr;
  logic     arvalid;
  logic     arready;
  data_t    rdata;
  resp_t    rresp;
  logic     rvalid;
  logic     rready;
  gpio_t    gpio_data_in;
  gpio_t    gpio_data_out;
  gpio_t    gpio_tri;
  gpio_t    gpio2_data_in;
  gpio_t    gpio2_data_out;
  gpio_t    gpio2_tri;
  irq_vec_t stat_in;
  logic     irq;

  reg_model_t model = '0;
  data_t      rng_state = 32'd71097;
  int         cycles = 0;

  gpio_interrupt_regs DUT (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_axi_awaddr   (awaddr),
    .s_axi_awvalid  (awvalid),
    .s_axi_awready  (awready),
    .s_axi_wdata    (wdata),
    .s_axi_wvalid   (wvalid),
    .s_axi_wready   (wready),
    .s_axi_bresp    (bresp),
    .s_axi_bvalid   (bvalid),
    .s_axi_bready   (bready),
    .s_axi_araddr   (araddr),
    .s_axi_arvalid  (arvalid),
    .s_axi_arready  (arready),
    .s_axi_rdata    (rdata),
    .s_axi_rresp    (rresp),
    .s_axi_rvalid   (rvalid),
    .s_axi_rready   (rready),
    .gpio_data_in   (gpio_data_in),
    .gpio_data_out  (gpio_data_out),
    .gpio_tri       (gpio_tri),
    .gpio2_data_in  (gpio2_data_in),
    .gpio2_data_out (gpio2_data_out),
    .gpio2_tri      (gpio2_tri),
    .stat_in        (stat_in),
    .irq            (irq)
  );

  always #20 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic data_t next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Expected readback and response from the register map
  function automatic data_t expected_read(input word_addr_t word, input reg_model_t m,
                                          input gpio_t in1, input gpio_t in2,
                                          output resp_t resp);
    data_t value;
    resp = RESP_OKAY;
    case (word)
      REG_GPIO_DATA:  value = in1;
      REG_GPIO_TRI:   value = m.gpio_tri;
      REG_GPIO2_DATA: value = in2;
      REG_GPIO2_TRI:  value = m.gpio2_tri;
      REG_IRQ_STAT:   value = data_t'(m.trap & m.mask);
      REG_IRQ_TRAP:   value = data_t'(m.trap);
      REG_IRQ_MASK:   value = data_t'(m.mask);
      REG_IRQ_FORCE:  value = '0;
      REG_IRQ_TRIG:   value = data_t'(m.trig);
      default: begin
        value = UNMAPPED_DATA;
        resp  = RESP_SLVERR;
      end
    endcase
    return value;
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // --------------------
  // AXI4-Lite bus tasks
  // --------------------

  task automatic axi_write(input word_addr_t word, input data_t data, input resp_t exp_resp);
    data_t      r;
    logic [1:0] gap;
    logic [1:0] hold;
    resp_t      resp_held;
    r = next_random();
    gap = r[1:0];
    hold = r[3:2];
    awaddr = {word, 2'b00};
    wdata = data;
    if (r[4]) begin
      awvalid = 1'b1;
      wvalid = 1'b1;
      while (!(awready && wready)) @(negedge aclk);
      @(negedge aclk);
      awvalid = 1'b0;
      wvalid = 1'b0;
    end else if (r[5]) begin
      // Address first and data after a gap
      awvalid = 1'b1;
      while (!awready) @(negedge aclk);
      @(negedge aclk);
      awvalid = 1'b0;
      repeat (gap) @(negedge aclk);
      wvalid = 1'b1;
      while (!wready) @(negedge aclk);
      @(negedge aclk);
      wvalid = 1'b0;
    end else begin
      wvalid = 1'b1;
      while (!wready) @(negedge aclk);
      @(negedge aclk);
      wvalid = 1'b0;
      repeat (gap) @(negedge aclk);
      awvalid = 1'b1;
      while (!awready) @(negedge aclk);
      @(negedge aclk);
      awvalid = 1'b0;
    end
    while (!bvalid) @(negedge aclk);
    resp_held = bresp;
    repeat (hold) begin
      @(negedge aclk);
      check_value("bvalid", data_t'(bvalid), 32'd1);
      check_value("bresp", data_t'(bresp), data_t'(resp_held));
    end
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    check_value($sformatf("bresp word %0d", word), data_t'(resp_held), data_t'(exp_resp));
  endtask

  task automatic axi_read(input word_addr_t word, output data_t data, output resp_t resp);
    data_t      r;
    logic [1:0] hold;
    data_t      data_held;
    resp_t      resp_held;
    r = next_random();
    hold = r[1:0];
    araddr = {word, 2'b00};
    arvalid = 1'b1;
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge aclk);
    data_held = rdata;
    resp_held = rresp;
    repeat (hold) begin
      @(negedge aclk);
      check_value("rvalid", data_t'(rvalid), 32'd1);
      check_value("rdata", rdata, data_held);
      check_value("rresp", data_t'(rresp), data_t'(resp_held));
    end
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
    data = data_held;
    resp = resp_held;
  endtask

  // Write through the bus and then mirror the effect in the model
  task automatic write_reg(input word_addr_t word, input data_t data);
    resp_t exp_resp;
    void'(expected_read(word, model, gpio_data_in, gpio2_data_in, exp_resp));
    axi_write(word, data, exp_resp);
    case (word)
      REG_GPIO_DATA:  model.gpio_out = data;
      REG_GPIO_TRI:   model.gpio_tri = data;
      REG_GPIO2_DATA: model.gpio2_out = data;
      REG_GPIO2_TRI:  model.gpio2_tri = data;
      REG_IRQ_TRAP:   model.trap &= ~data[1:0];
      REG_IRQ_MASK:   model.mask = data[1:0];
      REG_IRQ_FORCE:  model.trap |= data[1:0];
      REG_IRQ_TRIG:   model.trig = data[1:0];
      default: ;
    endcase
  endtask

  task automatic read_check(input word_addr_t word);
    data_t got_data;
    resp_t got_resp;
    data_t exp_data;
    resp_t exp_resp;
    axi_read(word, got_data, got_resp);
    exp_data = expected_read(word, model, gpio_data_in, gpio2_data_in, exp_resp);
    check_value($sformatf("rdata word %0d", word), got_data, exp_data);
    check_value($sformatf("rresp word %0d", word), data_t'(got_resp), data_t'(exp_resp));
  endtask

  task automatic check_all_regs();
    for (int w = 0; w <= 3; w++) read_check(word_addr_t'(w));
    for (int w = 71; w <= 76; w++) read_check(word_addr_t'(w));
  endtask

  task automatic check_ports();
    check_value("gpio_data_out", gpio_data_out, model.gpio_out);
    check_value("gpio_tri", gpio_tri, model.gpio_tri);
    check_value("gpio2_data_out", gpio2_data_out, model.gpio2_out);
    check_value("gpio2_tri", gpio2_tri, model.gpio2_tri);
  endtask

  task automatic wait_irq(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles) begin
      @(negedge aclk);
      n++;
    end
    check_value("irq", data_t'(irq), data_t'(level));
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    aresetn = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    gpio_data_in = '0;
    gpio2_data_in = '0;
    stat_in = '0;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);

    // Reset values
    check_value("bvalid", data_t'(bvalid), 32'd0);
    check_value("rvalid", data_t'(rvalid), 32'd0);
    check_value("irq", data_t'(irq), 32'd0);
    check_value("awready", data_t'(awready), 32'd1);
    check_value("wready", data_t'(wready), 32'd1);
    check_value("arready", data_t'(arready), 32'd1);
    check_ports();
    read_check(REG_GPIO_TRI);
    read_check(REG_GPIO2_TRI);
    for (int w = 72; w <= 76; w++) read_check(word_addr_t'(w));

    // Port registers with random data
    repeat (12) begin
      write_reg(word_addr_t'(next_random() % 4), next_random());
      check_ports();
      gpio_data_in = next_random();
      gpio2_data_in = next_random();
      for (int w = 0; w <= 3; w++) read_check(word_addr_t'(w));
    end

    // Unmapped offsets
    write_reg(7'd5, next_random());
    write_reg(7'd70, next_random());
    write_reg(7'd75, next_random());
    write_reg(7'd100, next_random());
    read_check(7'd5);
    read_check(7'd70);
    read_check(7'd75);
    read_check(7'd100);
    check_all_regs();
    check_ports();

    // Level interrupts with channel 0 masked on
    write_reg(REG_IRQ_TRIG, 32'd0);
    write_reg(REG_IRQ_MASK, 32'd1);
    stat_in = 2'b10;
    repeat (10) begin
      @(negedge aclk);
      check_value("irq", data_t'(irq), 32'd0);
    end
    model.trap = 2'b10;
    read_check(REG_IRQ_TRAP);
    read_check(REG_IRQ_STAT);
    stat_in = 2'b11;
    wait_irq(1'b1, 20);
    model.trap = 2'b11;
    read_check(REG_IRQ_TRAP);
    read_check(REG_IRQ_STAT);
    stat_in = 2'b00;
    repeat (2) @(negedge aclk);
    write_reg(REG_IRQ_TRAP, 32'd1);
    wait_irq(1'b0, 20);
    read_check(REG_IRQ_TRAP);
    read_check(REG_IRQ_STAT);
    write_reg(REG_IRQ_TRAP, 32'd2);
    read_check(REG_IRQ_TRAP);

    // Rising edge mode on channel 1
    write_reg(REG_IRQ_TRIG, 32'd2);
    stat_in = 2'b10;
    repeat (6) @(negedge aclk);
    model.trap = 2'b10;
    read_check(REG_IRQ_TRAP);
    write_reg(REG_IRQ_TRAP, 32'd2);
    read_check(REG_IRQ_TRAP);
    repeat (8) @(negedge aclk);
    read_check(REG_IRQ_TRAP);
    stat_in = 2'b00;

    // Force on both channels
    write_reg(REG_IRQ_MASK, 32'd3);
    write_reg(REG_IRQ_FORCE, 32'd3);
    read_check(REG_IRQ_TRAP);
    read_check(REG_IRQ_FORCE);
    read_check(REG_IRQ_STAT);
    wait_irq(1'b1, 20);
    write_reg(REG_IRQ_TRAP, 32'd3);
    wait_irq(1'b0, 20);
    read_check(REG_IRQ_STAT);

    // Write and read in flight together
    repeat (4) begin
      gpio2_data_in = next_random();
      fork
        write_reg(REG_GPIO_TRI, next_random());
        read_check(REG_GPIO2_DATA);
      join
      fork
        write_reg(REG_GPIO2_DATA, next_random());
        read_check(REG_GPIO_TRI);
      join
      check_ports();
    end
    check_all_regs();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* project.f */
rtl/gpio_regs_pkg.sv
rtl/axil_ctrl.sv
rtl/gpio_addr_decode.sv
rtl/gpio_port_regs.sv
rtl/gpio_irq_status.sv
rtl/gpio_interrupt_regs.sv
sim/tb_gpio_regs.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f project.f --top-module tb_gpio_regs -o sim_tb_gpio_regs

output="$(./obj_dir/sim_tb_gpio_regs 2>&1 || true)"
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
  exit 0
fi
exit 1
